//--- hw/rename_pkg.sv
// ####################
// rename package: register counts, widths and index types
// ####################

package rename_pkg;

    localparam int ways      = 4;   // rename and commit width
    localparam int arch_regs = 32;
    localparam int phys_regs = 64;

    localparam int arch_bits = $clog2(arch_regs);
    localparam int prf_bits  = $clog2(phys_regs);

    // architectural register number
    typedef logic [arch_bits-1:0] arch_idx_t;

    // physical register number
    typedef logic [prf_bits-1:0]  prf_idx_t;

    typedef logic [ways-1:0]      way_mask_t;   // one bit per way

endpackage

//--- hw/commit_if.sv
// ####################
// commit group bus: retiring mappings and the registers they displace
// ####################

`timescale 1ns/10ps

interface commit_if;

    rename_pkg::way_mask_t                         commit_valid;
    rename_pkg::arch_idx_t [rename_pkg::ways-1:0]  commit_arch;
    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  commit_prf;   // new rrat mapping
    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  commit_old;   // displaced, forwarded in group

    // rrat side, looks up and returns the displaced register
    modport rrat_side (
        input  commit_valid, commit_arch, commit_prf,
        output commit_old
    );

    modport tracker (input commit_valid, commit_arch, commit_prf, commit_old);

endinterface

//--- hw/rename_control.sv
// ####################
// rename control: in-order grant against free-register supply
// ####################

`timescale 1ns/10ps

module rename_control (
    input  rename_pkg::way_mask_t                        rename_req,
    input  rename_pkg::prf_idx_t [rename_pkg::ways-1:0]  cand_prf,
    input  rename_pkg::way_mask_t                        cand_valid,
    input  logic                                         except,
    output rename_pkg::way_mask_t                        grant,
    output rename_pkg::prf_idx_t [rename_pkg::ways-1:0]  alloc_prf,
    output logic                                         stall
);

    logic [1:0] taken;      // candidates used by lower ways
    logic       in_order;   // cleared once a requested way is refused

    always_comb begin
        taken     = '0;
        in_order  = 1'b1;
        grant     = '0;
        alloc_prf = '0;
        for (int i = 0; i < rename_pkg::ways; i++) begin
            if (rename_req[i] && !except) begin
                if (in_order && cand_valid[taken]) begin
                    grant[i]     = 1'b1;
                    alloc_prf[i] = cand_prf[taken];   // k-th granted way takes candidate k
                    taken        = taken + 2'd1;
                end else begin
                    in_order = 1'b0;   // higher ways wait behind this one
                end
            end
        end
        stall = !except && ((rename_req & ~grant) != '0);
    end

endmodule

//--- hw/map_tables.sv
// ####################
// speculative (rat) and retirement (rrat) map tables
// rat chains through the ways so each way sees the renames below it
// ####################

`timescale 1ns/10ps

module map_tables (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          except,
    input  rename_pkg::way_mask_t                         grant,
    input  rename_pkg::arch_idx_t [rename_pkg::ways-1:0]  dest_arch,
    input  rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  alloc_prf,
    input  rename_pkg::arch_idx_t [rename_pkg::ways-1:0]  src_a,
    input  rename_pkg::arch_idx_t [rename_pkg::ways-1:0]  src_b,
    output rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  src_a_prf,
    output rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  src_b_prf,
    commit_if.rrat_side                                   commit
);

    rename_pkg::prf_idx_t rat       [rename_pkg::arch_regs];
    rename_pkg::prf_idx_t rrat      [rename_pkg::arch_regs];
    rename_pkg::prf_idx_t rrat_next [rename_pkg::arch_regs];

    // stage i holds the rat after the writes of ways below i
    rename_pkg::prf_idx_t rat_stage [rename_pkg::ways+1][rename_pkg::arch_regs];

    always_comb begin
        rat_stage[0] = rat;
        for (int i = 0; i < rename_pkg::ways; i++) begin
            rat_stage[i+1] = rat_stage[i];
            if (grant[i]) begin
                rat_stage[i+1][dest_arch[i]] = alloc_prf[i];
            end
            src_a_prf[i] = rat_stage[i][src_a[i]];   // lower-way renames visible here
            src_b_prf[i] = rat_stage[i][src_b[i]];
        end
    end

    // displaced register per committing way
    always_comb begin
        for (int i = 0; i < rename_pkg::ways; i++) begin
            commit.commit_old[i] = rrat[commit.commit_arch[i]];
            for (int j = 0; j < i; j++) begin
                // an earlier way in the group already remapped this arch reg
                if (commit.commit_valid[j] &&
                    commit.commit_arch[j] == commit.commit_arch[i]) begin
                    commit.commit_old[i] = commit.commit_prf[j];
                end
            end
        end
    end

    // later ways win on the same arch reg
    always_comb begin
        rrat_next = rrat;
        for (int i = 0; i < rename_pkg::ways; i++) begin
            if (commit.commit_valid[i]) begin
                rrat_next[commit.commit_arch[i]] = commit.commit_prf[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int n = 0; n < rename_pkg::arch_regs; n++) begin
                rat[n]  <= rename_pkg::prf_idx_t'(n);   // identity mapping
                rrat[n] <= rename_pkg::prf_idx_t'(n);
            end
        end else begin
            rrat <= rrat_next;
            if (except) begin
                rat <= rrat_next;   // recover to committed state incl. this cycle's commits
            end else begin
                rat <= rat_stage[rename_pkg::ways];
            end
        end
    end

endmodule

//--- hw/free_list.sv
// ####################
// free list: speculative and retirement free vectors
// offers the four lowest speculatively free registers
// ####################

`timescale 1ns/10ps

module free_list (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          except,
    input  rename_pkg::way_mask_t                         grant,
    input  rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  alloc_prf,
    commit_if.tracker                                     commit,
    output rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  cand_prf,
    output rename_pkg::way_mask_t                         cand_valid,
    output logic [rename_pkg::phys_regs-1:0]              retire_free
);

    localparam int spare_regs = rename_pkg::phys_regs - rename_pkg::arch_regs;

    logic [rename_pkg::phys_regs-1:0] spec_free;
    logic [rename_pkg::phys_regs-1:0] spec_next;
    logic [rename_pkg::phys_regs-1:0] retire_next;
    logic [2:0]                       found;   // candidates picked so far

    // lowest-first scan
    always_comb begin
        found      = '0;
        cand_prf   = '0;
        cand_valid = '0;
        for (int r = 0; r < rename_pkg::phys_regs; r++) begin
            if (spec_free[r] && found < 3'(rename_pkg::ways)) begin
                cand_prf[found[1:0]]   = rename_pkg::prf_idx_t'(r);
                cand_valid[found[1:0]] = 1'b1;
                found                  = found + 3'd1;
            end
        end
    end

    always_comb begin
        spec_next   = spec_free;
        retire_next = retire_free;
        for (int i = 0; i < rename_pkg::ways; i++) begin
            if (grant[i]) begin
                spec_next[alloc_prf[i]] = 1'b0;
            end
        end
        // per way in order, so a same-group overwrite frees the earlier way's reg
        for (int i = 0; i < rename_pkg::ways; i++) begin
            if (commit.commit_valid[i]) begin
                spec_next[commit.commit_old[i]]   = 1'b1;
                retire_next[commit.commit_prf[i]] = 1'b0;
                retire_next[commit.commit_old[i]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            spec_free   <= {{spare_regs{1'b1}}, {rename_pkg::arch_regs{1'b0}}};
            retire_free <= {{spare_regs{1'b1}}, {rename_pkg::arch_regs{1'b0}}};
        end else begin
            retire_free <= retire_next;
            spec_free   <= except ? retire_next : spec_next;
        end
    end

    for (genvar i = 0; i < rename_pkg::ways; i++) begin : g_alloc_chk
        // control must only hand out registers this list still holds
        assert property (@(posedge clock) disable iff (reset)
            grant[i] |-> spec_free[alloc_prf[i]])
            else $error("free_list: way %0d allocated busy register %0d", i, alloc_prf[i]);
    end

endmodule

//--- hw/ready_list.sv
// ####################
// ready list: one ready bit per physical register
// ####################

`timescale 1ns/10ps

module ready_list (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          except,
    input  rename_pkg::way_mask_t                         cdb_valid,
    input  rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  cdb_tag,
    input  rename_pkg::way_mask_t                         grant,
    input  rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  alloc_prf,
    commit_if.tracker                                     commit,
    input  logic [rename_pkg::phys_regs-1:0]              retire_free,
    input  rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  src_a_prf,
    input  rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  src_b_prf,
    output rename_pkg::way_mask_t                         src_a_ready,
    output rename_pkg::way_mask_t                         src_b_ready
);

    logic [rename_pkg::phys_regs-1:0] ready;
    logic [rename_pkg::phys_regs-1:0] ready_next;
    logic [rename_pkg::phys_regs-1:0] ready_rebuild;   // used on exception

    always_comb begin
        ready_next    = ready;
        ready_rebuild = ~retire_free;
        for (int i = 0; i < rename_pkg::ways; i++) begin
            if (grant[i]) ready_next[alloc_prf[i]] = 1'b0;
        end
        for (int i = 0; i < rename_pkg::ways; i++) begin
            if (commit.commit_valid[i]) begin
                ready_next[commit.commit_old[i]]    = 1'b0;
                // track this cycle's retirement changes too
                ready_rebuild[commit.commit_prf[i]] = 1'b1;
                ready_rebuild[commit.commit_old[i]] = 1'b0;
            end
        end
        for (int i = 0; i < rename_pkg::ways; i++) begin
            if (cdb_valid[i]) ready_next[cdb_tag[i]] = 1'b1;   // result written back
        end
    end

    // in-group forwarded sources hit freshly allocated regs, which read not ready
    always_comb begin
        for (int i = 0; i < rename_pkg::ways; i++) begin
            src_a_ready[i] = ready[src_a_prf[i]];
            src_b_ready[i] = ready[src_b_prf[i]];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ready <= {{(rename_pkg::phys_regs-rename_pkg::arch_regs){1'b0}},
                      {rename_pkg::arch_regs{1'b1}}};
        end else begin
            ready <= except ? ready_rebuild : ready_next;
        end
    end

endmodule

//--- hw/rename_unit.sv
// ####################
// rename unit top: control, map tables, free and ready lists
// ####################

`timescale 1ns/10ps

module rename_unit (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          except,
    input  rename_pkg::way_mask_t                         rename_req,
    input  rename_pkg::arch_idx_t [rename_pkg::ways-1:0]  dest_arch,
    input  rename_pkg::arch_idx_t [rename_pkg::ways-1:0]  src_a,
    input  rename_pkg::arch_idx_t [rename_pkg::ways-1:0]  src_b,
    input  rename_pkg::way_mask_t                         cdb_valid,
    input  rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  cdb_tag,
    input  rename_pkg::way_mask_t                         commit_valid,
    input  rename_pkg::arch_idx_t [rename_pkg::ways-1:0]  commit_arch,
    input  rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  commit_prf,
    output rename_pkg::way_mask_t                         grant,
    output rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  dest_prf,
    output logic                                          stall,
    output rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  src_a_prf,
    output rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  src_b_prf,
    output rename_pkg::way_mask_t                         src_a_ready,
    output rename_pkg::way_mask_t                         src_b_ready
);

    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0] cand_prf;
    rename_pkg::way_mask_t                        cand_valid;
    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0] alloc_prf;
    logic [rename_pkg::phys_regs-1:0]             retire_free;

    commit_if commit_bus ();

    assign commit_bus.commit_valid = commit_valid;   // from rob
    assign commit_bus.commit_arch  = commit_arch;
    assign commit_bus.commit_prf   = commit_prf;
    assign dest_prf                = alloc_prf;

    rename_control ctrl (
        .rename_req, .cand_prf, .cand_valid, .except,
        .grant, .alloc_prf, .stall
    );

    map_tables tables (
        .clock, .reset, .except, .grant, .dest_arch, .alloc_prf,
        .src_a, .src_b, .src_a_prf, .src_b_prf,
        .commit (commit_bus.rrat_side)
    );

    free_list free (
        .clock, .reset, .except, .grant, .alloc_prf,
        .commit (commit_bus.tracker),
        .cand_prf, .cand_valid, .retire_free
    );

    ready_list ready (
        .clock, .reset, .except, .cdb_valid, .cdb_tag, .grant, .alloc_prf,
        .commit (commit_bus.tracker),
        .retire_free, .src_a_prf, .src_b_prf, .src_a_ready, .src_b_ready
    );

endmodule

//--- verif/rename_unit_tb.sv
// ####################
// rename unit testbench: reference map model checked by assertions
// ####################

`timescale 1ns/10ps

module rename_unit_tb;

    localparam int num_tests   = 6;
    localparam int cycle_limit = 40 * num_tests + 16;   // two resets

    logic                                          clock;
    logic                                          reset;
    logic                                          except;
    rename_pkg::way_mask_t                         rename_req;
    rename_pkg::arch_idx_t [rename_pkg::ways-1:0]  dest_arch;
    rename_pkg::arch_idx_t [rename_pkg::ways-1:0]  src_a;
    rename_pkg::arch_idx_t [rename_pkg::ways-1:0]  src_b;
    rename_pkg::way_mask_t                         cdb_valid;
    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  cdb_tag;
    rename_pkg::way_mask_t                         commit_valid;
    rename_pkg::arch_idx_t [rename_pkg::ways-1:0]  commit_arch;
    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  commit_prf;
    rename_pkg::way_mask_t                         grant;
    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  dest_prf;
    logic                                          stall;
    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  src_a_prf;
    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  src_b_prf;
    rename_pkg::way_mask_t                         src_a_ready;
    rename_pkg::way_mask_t                         src_b_ready;

    // reference model
    rename_pkg::prf_idx_t             ref_rat  [rename_pkg::arch_regs];
    rename_pkg::prf_idx_t             ref_rrat [rename_pkg::arch_regs];
    logic [rename_pkg::phys_regs-1:0] ref_free;    // speculative
    logic [rename_pkg::phys_regs-1:0] ret_free;
    logic [rename_pkg::phys_regs-1:0] ref_ready;
    rename_pkg::arch_idx_t            pend_arch [$];   // renamed, not yet committed
    rename_pkg::prf_idx_t             pend_prf  [$];
    rename_pkg::prf_idx_t             old_prf;

    rename_pkg::way_mask_t                         exp_grant;
    rename_pkg::way_mask_t                         exp_a_rdy;
    rename_pkg::way_mask_t                         exp_b_rdy;
    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  exp_a_prf;
    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  exp_b_prf;
    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  exp_cand;    // four lowest free
    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  exp_dest;
    rename_pkg::prf_idx_t  [rename_pkg::ways-1:0]  dest_mask;   // granted ways only
    logic                                          exp_stall;
    int                                            found;
    int                                            taken;
    logic                                          in_order;

    string test_names [num_tests] = '{"reset_map", "rename_ready", "group_forward",
                                      "exhaust", "commit_free", "except_restore"};
    int          test_no;
    int          err_count [num_tests];
    int          cycles;
    logic [31:0] rng_state;

    rename_unit dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        if (reset) begin
            for (int n = 0; n < rename_pkg::arch_regs; n++) begin
                ref_rat[n]  = rename_pkg::prf_idx_t'(n);
                ref_rrat[n] = rename_pkg::prf_idx_t'(n);
            end
            ref_free  = {{32{1'b1}}, {32{1'b0}}};
            ret_free  = {{32{1'b1}}, {32{1'b0}}};
            ref_ready = {{32{1'b0}}, {32{1'b1}}};
            pend_arch.delete();
            pend_prf.delete();
        end else begin
            for (int i = 0; i < rename_pkg::ways; i++) begin
                if (commit_valid[i]) begin
                    old_prf                 = ref_rrat[commit_arch[i]];
                    ref_rrat[commit_arch[i]] = commit_prf[i];
                    ret_free[commit_prf[i]] = 1'b0;
                    ret_free[old_prf]       = 1'b1;
                    ref_free[old_prf]       = 1'b1;
                    ref_ready[old_prf]      = 1'b0;
                end
            end
            if (except) begin
                ref_rat   = ref_rrat;   // committed state wins
                ref_free  = ret_free;
                ref_ready = ~ret_free;
                pend_arch.delete();
                pend_prf.delete();
            end else begin
                for (int i = 0; i < rename_pkg::ways; i++) begin
                    if (exp_grant[i]) begin
                        ref_rat[dest_arch[i]]  = exp_dest[i];
                        ref_free[exp_dest[i]]  = 1'b0;
                        ref_ready[exp_dest[i]] = 1'b0;
                        pend_arch.push_back(dest_arch[i]);
                        pend_prf.push_back(exp_dest[i]);
                    end
                end
                for (int i = 0; i < rename_pkg::ways; i++) begin
                    if (cdb_valid[i]) ref_ready[cdb_tag[i]] = 1'b1;
                end
            end
        end
    end

    // expected outputs for the current cycle
    always_comb begin
        found    = 0;
        exp_cand = '0;
        for (int r = 0; r < rename_pkg::phys_regs; r++) begin
            if (ref_free[r] && found < rename_pkg::ways) begin
                exp_cand[found] = rename_pkg::prf_idx_t'(r);   // lowest first
                found++;
            end
        end
        taken     = 0;
        in_order  = 1'b1;
        exp_grant = '0;
        exp_dest  = '0;
        dest_mask = '0;
        for (int i = 0; i < rename_pkg::ways; i++) begin
            if (rename_req[i] && !except) begin
                if (in_order && taken < found) begin
                    exp_grant[i] = 1'b1;
                    exp_dest[i]  = exp_cand[taken];
                    dest_mask[i] = '1;
                    taken++;
                end else begin
                    in_order = 1'b0;
                end
            end
        end
        exp_stall = !except && ((rename_req & ~exp_grant) != '0);
        for (int i = 0; i < rename_pkg::ways; i++) begin
            exp_a_prf[i] = ref_rat[src_a[i]];
            exp_b_prf[i] = ref_rat[src_b[i]];
            exp_a_rdy[i] = ref_ready[exp_a_prf[i]];
            exp_b_rdy[i] = ref_ready[exp_b_prf[i]];
            for (int j = 0; j < i; j++) begin
                if (exp_grant[j] && dest_arch[j] == src_a[i]) begin
                    exp_a_prf[i] = exp_dest[j];   // fresh register, never ready
                    exp_a_rdy[i] = 1'b0;
                end
                if (exp_grant[j] && dest_arch[j] == src_b[i]) begin
                    exp_b_prf[i] = exp_dest[j];
                    exp_b_rdy[i] = 1'b0;
                end
            end
        end
    end

    task automatic value_error(input int k, input string what,
                               input logic [63:0] exp_v, input logic [63:0] act_v);
        err_count[k]++;
        $display("ERR %s %s expected %0h actual %0h", test_names[k], what, exp_v, act_v);
    endtask

    chk_grant: assert property (@(posedge clock) disable iff (reset) grant == exp_grant)
        else value_error($sampled(test_no), "grant", 64'($sampled(exp_grant)), 64'($sampled(grant)));
    chk_stall: assert property (@(posedge clock) disable iff (reset) stall == exp_stall)
        else value_error($sampled(test_no), "stall", 64'($sampled(exp_stall)), 64'($sampled(stall)));
    chk_src: assert property (@(posedge clock) disable iff (reset)
        {src_a_prf, src_b_prf} == {exp_a_prf, exp_b_prf})
        else value_error($sampled(test_no), "src_prf", 64'($sampled({exp_a_prf, exp_b_prf})),
                         64'($sampled({src_a_prf, src_b_prf})));
    chk_ready: assert property (@(posedge clock) disable iff (reset)
        {src_a_ready, src_b_ready} == {exp_a_rdy, exp_b_rdy})
        else value_error($sampled(test_no), "src_ready", 64'($sampled({exp_a_rdy, exp_b_rdy})),
                         64'($sampled({src_a_ready, src_b_ready})));
    chk_dest: assert property (@(posedge clock) disable iff (reset)
        (dest_prf & dest_mask) == exp_dest)
        else value_error($sampled(test_no), "dest_prf", 64'($sampled(exp_dest)),
                         64'($sampled(dest_prf & dest_mask)));

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic apply_reset();
        reset <= 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic drive_idle();
        rename_req   <= '0;
        cdb_valid    <= '0;
        commit_valid <= '0;
        except       <= 1'b0;
    endtask

    task automatic random_group(input rename_pkg::way_mask_t req);
        rename_pkg::arch_idx_t [rename_pkg::ways-1:0] d;
        rename_pkg::arch_idx_t [rename_pkg::ways-1:0] a;
        rename_pkg::arch_idx_t [rename_pkg::ways-1:0] b;
        for (int i = 0; i < rename_pkg::ways; i++) begin
            d[i] = rename_pkg::arch_idx_t'(next_random());
            a[i] = rename_pkg::arch_idx_t'(next_random());
            b[i] = rename_pkg::arch_idx_t'(next_random());
        end
        rename_req <= req;
        dest_arch  <= d;
        src_a      <= a;
        src_b      <= b;
    endtask

    // oldest pending renames retire first
    task automatic drive_commits(input int n);
        rename_pkg::way_mask_t                        v;
        rename_pkg::arch_idx_t [rename_pkg::ways-1:0] a;
        rename_pkg::prf_idx_t  [rename_pkg::ways-1:0] p;
        v = '0;
        a = '0;
        p = '0;
        for (int i = 0; i < rename_pkg::ways; i++) begin
            if (i < n && pend_prf.size() > 0) begin
                v[i] = 1'b1;
                a[i] = pend_arch.pop_front();
                p[i] = pend_prf.pop_front();
            end
        end
        commit_valid <= v;
        commit_arch  <= a;
        commit_prf   <= p;
    endtask

    task automatic begin_test(input int k);
        @(posedge clock);
        test_no = k;
    endtask

    task automatic end_test();
        @(posedge clock);
        drive_idle();
        @(negedge clock);   // checks of the last cycle are done
        $display("test %0d %-15s %s, %0d errors", test_no, test_names[test_no],
                 err_count[test_no] == 0 ? "passed" : "failed", err_count[test_no]);
    endtask

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rename_pkg::arch_idx_t d;
        rename_pkg::arch_idx_t [rename_pkg::ways-1:0] grp;
        int failed;
        reset        = 1'b1;
        except       = 1'b0;
        rename_req   = '0;
        dest_arch    = '0;
        src_a        = '0;
        src_b        = '0;
        cdb_valid    = '0;
        cdb_tag      = '0;
        commit_valid = '0;
        commit_arch  = '0;
        commit_prf   = '0;
        rng_state    = 32'h5981;
        test_no      = 0;
        failed       = 0;
        for (int k = 0; k < num_tests; k++) err_count[k] = 0;
        apply_reset();

        begin_test(0);
        for (int c = 0; c < 8; c++) begin
            @(posedge clock);
            for (int i = 0; i < rename_pkg::ways; i++) begin
                src_a[i] <= rename_pkg::arch_idx_t'(4 * c + i);
                src_b[i] <= rename_pkg::arch_idx_t'(31 - 4 * c - i);
            end
        end
        end_test();

        begin_test(1);
        d = rename_pkg::arch_idx_t'(next_random());
        rename_req   <= 4'b0001;
        dest_arch[0] <= d;
        @(posedge clock);
        rename_req <= '0;
        src_a[0]   <= d;
        src_b[0]   <= d;
        @(posedge clock);
        cdb_valid  <= 4'b0001;
        cdb_tag[0] <= pend_prf[$];
        @(posedge clock);
        cdb_valid <= '0;
        end_test();

        begin_test(2);
        for (int c = 0; c < 3; c++) begin
            @(posedge clock);
            random_group(4'hf);
            for (int i = 0; i < rename_pkg::ways; i++) begin
                grp[i] = rename_pkg::arch_idx_t'(next_random());
            end
            dest_arch <= grp;   // upper ways read dests of this same group
            for (int i = 1; i < rename_pkg::ways; i++) begin
                src_a[i] <= grp[i-1];
                src_b[i] <= grp[0];
            end
        end
        end_test();

        begin_test(3);
        apply_reset();
        for (int c = 0; c < 10; c++) begin
            @(posedge clock);
            random_group(c == 7 ? 4'h3 : 4'hf);   // two left, then none
        end
        @(posedge clock);
        random_group(4'b0110);
        end_test();

        begin_test(4);
        random_group(4'hf);   // stalls, list is empty
        drive_commits(4);
        @(posedge clock);
        random_group(4'hf);
        dest_arch <= {rename_pkg::ways{rename_pkg::arch_idx_t'(7)}};
        commit_valid <= '0;
        while (pend_prf.size() > 0) begin
            @(posedge clock);
            rename_req <= '0;
            drive_commits(4);
        end
        end_test();

        begin_test(5);
        random_group(4'hf);
        @(posedge clock);
        random_group(4'hf);
        @(posedge clock);
        random_group(4'hf);
        drive_commits(2);
        cdb_valid  <= 4'b0011;
        cdb_tag[0] <= pend_prf[0];
        cdb_tag[1] <= pend_prf[1];
        @(posedge clock);
        random_group(4'hf);   // overridden by the exception
        drive_commits(2);
        cdb_valid <= '0;
        except    <= 1'b1;
        for (int c = 0; c < 8; c++) begin
            @(posedge clock);
            drive_idle();
            random_group(4'h0);
            for (int i = 0; i < rename_pkg::ways; i++) begin
                src_a[i] <= rename_pkg::arch_idx_t'(4 * c + i);
            end
        end
        end_test();

        for (int k = 0; k < num_tests; k++) begin
            if (err_count[k] != 0) failed++;
        end
        $display("tests %0d, passed %0d, failed %0d", num_tests, num_tests - failed, failed);
        if (failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- rename_unit.f
hw/rename_pkg.sv
hw/commit_if.sv
hw/rename_control.sv
hw/map_tables.sv
hw/free_list.sv
hw/ready_list.sv
hw/rename_unit.sv
verif/rename_unit_tb.sv

//--- Makefile
TB = rename_unit_tb

lint:
	verilator --lint-only -Wall --timing --assert -f rename_unit.f --top-module $(TB)

sim:
	verilator --binary --timing --assert -f rename_unit.f --top-module $(TB) -o rename_sim
	./obj_dir/rename_sim | tee sim.log
	grep -q '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: lint sim clean
